// File: demosaicPkg.sv
package demosaicPkg;

	// Frame geometry, kept small for simulation
	localparam int frameWidth = 8;
	localparam int frameHeight = 6;
	localparam int framePixels = frameWidth * frameHeight;

	// Beats after the last pixel until the window is centred on it
	localparam int flushBeats = frameWidth + 1;

	typedef logic [7:0] pixelT;
	typedef logic [3:0] coordT;
	typedef logic [8:0] gradSumT;
	typedef logic [23:0] activityT;
	typedef logic [7:0] thresholdT;
	typedef logic [2:0] wbAddrT;
	typedef logic [31:0] wbDataT;
	typedef logic [$clog2(framePixels)-1:0] beatCntT;

	typedef enum logic [1:0] {
		seqFill,
		seqRun,
		seqFlush
	} seqStateT;

	// Register map
	localparam wbAddrT addrBreak0 = 3'd0;
	localparam wbAddrT addrBreak1 = 3'd1;
	localparam wbAddrT addrBreak2 = 3'd2;
	localparam wbAddrT addrBreak3 = 3'd3;
	localparam wbAddrT addrThreshold = 3'd4;
	localparam wbAddrT addrActivity = 3'd5;

	localparam activityT defaultBreak0 = 24'd200;
	localparam activityT defaultBreak1 = 24'd300;
	localparam activityT defaultBreak2 = 24'd450;
	localparam activityT defaultBreak3 = 24'd900;

	// Threshold per activity class, last entry is also the reset value
	localparam thresholdT thresholdLevels [5] = '{8'd50, 8'd40, 8'd20, 8'd15, 8'd8};

endpackage

// File: bayerWindow.sv
`timescale 1ns/1ps

module bayerWindow (
	input logic clk,
	input logic reset,
	input demosaicPkg::pixelT inData,
	input logic inValid,
	output demosaicPkg::pixelT tap00,
	output demosaicPkg::pixelT tap01,
	output demosaicPkg::pixelT tap02,
	output demosaicPkg::pixelT tap10,
	output demosaicPkg::pixelT tap11,
	output demosaicPkg::pixelT tap12,
	output demosaicPkg::pixelT tap20,
	output demosaicPkg::pixelT tap21,
	output demosaicPkg::pixelT tap22,
	output demosaicPkg::coordT centreX,
	output demosaicPkg::coordT centreY,
	output logic centreValid,
	output logic centreLast
);
	import demosaicPkg::*;

	// Row 0 is the oldest line, column 0 the oldest sample
	pixelT lineA [frameWidth];
	pixelT lineB [frameWidth];

	seqStateT state;
	beatCntT beatCnt;
	coordT posX;
	coordT posY;

	// Two line delays and the 3x3 window, frozen while inValid is low
	always_ff @(posedge clk) begin
		if (inValid) begin
			lineA[0] <= inData;
			lineB[0] <= lineA[frameWidth-1];
			for (int i = 1; i < frameWidth; i++) begin
				lineA[i] <= lineA[i-1];
				lineB[i] <= lineB[i-1];
			end
			tap00 <= tap01;
			tap01 <= tap02;
			tap02 <= lineB[frameWidth-1];
			tap10 <= tap11;
			tap11 <= tap12;
			tap12 <= lineA[frameWidth-1];
			tap20 <= tap21;
			tap21 <= tap22;
			tap22 <= inData;
		end
	end

	// Frame sequencer, centre lags the input by flushBeats beats
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= seqFill;
			beatCnt <= '0;
			posX <= '0;
			posY <= '0;
			centreX <= '0;
			centreY <= '0;
			centreValid <= 1'b0;
			centreLast <= 1'b0;
		end else if (inValid) begin
			centreValid <= (state != seqFill);
			centreLast <= (state == seqFlush) && (beatCnt == beatCntT'(flushBeats - 1));
			centreX <= posX;
			centreY <= posY;

			beatCnt <= beatCnt + 1'b1;
			case (state)
				seqFill: begin
					if (beatCnt == beatCntT'(flushBeats - 1)) begin
						state <= seqRun;
						beatCnt <= '0;
					end
				end
				seqRun: begin
					if (beatCnt == beatCntT'(framePixels - flushBeats - 1)) begin
						state <= seqFlush;
						beatCnt <= '0;
					end
				end
				default: begin
					if (beatCnt == beatCntT'(flushBeats - 1)) begin
						state <= seqFill;
						beatCnt <= '0;
					end
				end
			endcase

			// Position walks only while real pixels reach the centre
			if (state == seqFill) begin
				posX <= '0;
				posY <= '0;
			end else if (posX == coordT'(frameWidth - 1)) begin
				posX <= '0;
				posY <= posY + 1'b1;
			end else begin
				posX <= posX + 1'b1;
			end
		end
	end

endmodule

// File: greenInterp.sv
`timescale 1ns/1ps

module greenInterp (
	input logic clk,
	input logic reset,
	input logic inValid,
	input demosaicPkg::pixelT tap00,
	input demosaicPkg::pixelT tap01,
	input demosaicPkg::pixelT tap02,
	input demosaicPkg::pixelT tap10,
	input demosaicPkg::pixelT tap11,
	input demosaicPkg::pixelT tap12,
	input demosaicPkg::pixelT tap20,
	input demosaicPkg::pixelT tap21,
	input demosaicPkg::pixelT tap22,
	input demosaicPkg::coordT centreX,
	input demosaicPkg::coordT centreY,
	input logic centreValid,
	input logic centreLast,
	output demosaicPkg::pixelT red,
	output demosaicPkg::pixelT green,
	output demosaicPkg::pixelT blue,
	output logic pixelValid,
	output logic frameDone,
	output demosaicPkg::gradSumT activity
);
	import demosaicPkg::*;

	function automatic pixelT absDiff(input pixelT a, input pixelT b);
		return (a > b) ? a - b : b - a;
	endfunction

	function automatic pixelT floorMean(input pixelT a, input pixelT b);
		gradSumT sum;
		sum = gradSumT'(a) + gradSumT'(b);
		return pixelT'(sum >> 1);
	endfunction

	logic atLeft, atRight, atTop, atBottom;
	pixelT left, right, up, down;
	pixelT gH, gV;

	pixelT h1, v1, gH1, gV1, centre1, gSel2, centre2;
	gradSumT grad2;
	logic [1:0] site1, site2;
	logic valid1, valid2, valid3;
	logic last1, last2, last3;

	// Neighbours outside the frame read as zero
	always_comb begin
		atLeft = (centreX == '0);
		atRight = (centreX == coordT'(frameWidth - 1));
		atTop = (centreY == '0);
		atBottom = (centreY == coordT'(frameHeight - 1));
		left = atLeft ? '0 : tap10;
		right = atRight ? '0 : tap12;
		up = atTop ? '0 : tap01;
		down = atBottom ? '0 : tap21;
		// At a border only one neighbour exists
		gH = atLeft ? right : (atRight ? left : floorMean(left, right));
		gV = atTop ? down : (atBottom ? up : floorMean(up, down));
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			{valid1, valid2, valid3} <= '0;
			{last1, last2, last3} <= '0;
		end else if (inValid) begin
			valid1 <= centreValid;
			valid2 <= valid1;
			valid3 <= valid2;
			last1 <= centreLast;
			last2 <= last1;
			last3 <= last2;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid) begin
			// Gradients and directional averages
			h1 <= absDiff(left, right);
			v1 <= absDiff(up, down);
			gH1 <= gH;
			gV1 <= gV;
			centre1 <= tap11;
			site1 <= {centreY[0], centreX[0]};

			// Interpolate along the smoother direction
			if (h1 > v1) begin
				gSel2 <= gV1;
			end else if (h1 < v1) begin
				gSel2 <= gH1;
			end else begin
				gSel2 <= floorMean(gH1, gV1);
			end
			grad2 <= gradSumT'(h1) + gradSumT'(v1);
			centre2 <= centre1;
			site2 <= site1;

			case (site2)
				2'b01: begin
					// Blue site
					red <= '0;
					green <= gSel2;
					blue <= centre2;
					activity <= grad2;
				end
				2'b10: begin
					// Red site
					red <= centre2;
					green <= gSel2;
					blue <= '0;
					activity <= grad2;
				end
				default: begin
					red <= '0;
					green <= centre2;
					blue <= '0;
					activity <= '0;
				end
			endcase
		end
	end

	assign pixelValid = valid3 & inValid;
	assign frameDone = last3 & inValid;

endmodule

// File: greyActivity.sv
`timescale 1ns/1ps

module greyActivity (
	input logic clk,
	input logic reset,
	input demosaicPkg::gradSumT activity,
	input logic pixelValid,
	input logic frameDone,
	input demosaicPkg::activityT break0,
	input demosaicPkg::activityT break1,
	input demosaicPkg::activityT break2,
	input demosaicPkg::activityT break3,
	output demosaicPkg::thresholdT threshold,
	output demosaicPkg::activityT lastActivity
);
	import demosaicPkg::*;

	activityT accum;
	activityT frameSum;
	thresholdT level;

	// Sum including the pixel on this beat
	always_comb begin
		frameSum = accum + activityT'(activity);
		if (frameSum < break0) begin
			level = thresholdLevels[0];
		end else if (frameSum < break1) begin
			level = thresholdLevels[1];
		end else if (frameSum < break2) begin
			level = thresholdLevels[2];
		end else if (frameSum < break3) begin
			level = thresholdLevels[3];
		end else begin
			level = thresholdLevels[4];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			accum <= '0;
			lastActivity <= '0;
			threshold <= thresholdLevels[4];
		end else if (pixelValid) begin
			if (frameDone) begin
				lastActivity <= frameSum;
				threshold <= level;
				accum <= '0;
			end else begin
				accum <= frameSum;
			end
		end
	end

endmodule

// File: thresholdRegs.sv
`timescale 1ns/1ps

module thresholdRegs (
	input logic clk,
	input logic reset,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input demosaicPkg::wbAddrT wbAddr,
	input demosaicPkg::wbDataT wbDataIn,
	output demosaicPkg::wbDataT wbDataOut,
	output logic wbAck,
	input demosaicPkg::thresholdT threshold,
	input demosaicPkg::activityT lastActivity,
	output demosaicPkg::activityT break0,
	output demosaicPkg::activityT break1,
	output demosaicPkg::activityT break2,
	output demosaicPkg::activityT break3
);
	import demosaicPkg::*;

	logic request;
	wbDataT readWord;

	// No new request in the cycle right after an ack
	assign request = wbCyc & wbStb & ~wbAck;

	always_ff @(posedge clk) begin
		if (reset) begin
			wbAck <= 1'b0;
			break0 <= defaultBreak0;
			break1 <= defaultBreak1;
			break2 <= defaultBreak2;
			break3 <= defaultBreak3;
		end else begin
			wbAck <= request;
			if (request && wbWe) begin
				case (wbAddr)
					addrBreak0: break0 <= activityT'(wbDataIn);
					addrBreak1: break1 <= activityT'(wbDataIn);
					addrBreak2: break2 <= activityT'(wbDataIn);
					addrBreak3: break3 <= activityT'(wbDataIn);
					default: begin
					end
				endcase
			end
		end
	end

	always_comb begin
		case (wbAddr)
			addrBreak0: readWord = wbDataT'(break0);
			addrBreak1: readWord = wbDataT'(break1);
			addrBreak2: readWord = wbDataT'(break2);
			addrBreak3: readWord = wbDataT'(break3);
			addrThreshold: readWord = wbDataT'(threshold);
			addrActivity: readWord = wbDataT'(lastActivity);
			default: readWord = '0;
		endcase
	end

	// Read data lands together with the ack
	always_ff @(posedge clk) begin
		if (request) begin
			wbDataOut <= readWord;
		end
	end

endmodule

// File: acpiDemosaic.sv
`timescale 1ns/1ps

module acpiDemosaic (
	input logic clk,
	input logic reset,
	input demosaicPkg::pixelT inData,
	input logic inValid,
	output demosaicPkg::pixelT red,
	output demosaicPkg::pixelT green,
	output demosaicPkg::pixelT blue,
	output logic pixelValid,
	output logic frameDone,
	output demosaicPkg::thresholdT threshold,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input demosaicPkg::wbAddrT wbAddr,
	input demosaicPkg::wbDataT wbDataIn,
	output demosaicPkg::wbDataT wbDataOut,
	output logic wbAck
);
	import demosaicPkg::*;

	pixelT tap00, tap01, tap02;
	pixelT tap10, tap11, tap12;
	pixelT tap20, tap21, tap22;
	coordT centreX, centreY;
	logic centreValid, centreLast;
	gradSumT activity;
	activityT lastActivity;
	activityT break0, break1, break2, break3;

	bayerWindow bayerWindow_inst (
		.clk(clk), .reset(reset), .inData(inData), .inValid(inValid),
		.tap00(tap00), .tap01(tap01), .tap02(tap02),
		.tap10(tap10), .tap11(tap11), .tap12(tap12),
		.tap20(tap20), .tap21(tap21), .tap22(tap22),
		.centreX(centreX), .centreY(centreY),
		.centreValid(centreValid), .centreLast(centreLast)
	);

	greenInterp greenInterp_inst (
		.clk(clk), .reset(reset), .inValid(inValid),
		.tap00(tap00), .tap01(tap01), .tap02(tap02),
		.tap10(tap10), .tap11(tap11), .tap12(tap12),
		.tap20(tap20), .tap21(tap21), .tap22(tap22),
		.centreX(centreX), .centreY(centreY),
		.centreValid(centreValid), .centreLast(centreLast),
		.red(red), .green(green), .blue(blue),
		.pixelValid(pixelValid), .frameDone(frameDone), .activity(activity)
	);

	greyActivity greyActivity_inst (
		.clk(clk), .reset(reset), .activity(activity),
		.pixelValid(pixelValid), .frameDone(frameDone),
		.break0(break0), .break1(break1), .break2(break2), .break3(break3),
		.threshold(threshold), .lastActivity(lastActivity)
	);

	thresholdRegs thresholdRegs_inst (
		.clk(clk), .reset(reset),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAddr(wbAddr),
		.wbDataIn(wbDataIn), .wbDataOut(wbDataOut), .wbAck(wbAck),
		.threshold(threshold), .lastActivity(lastActivity),
		.break0(break0), .break1(break1), .break2(break2), .break3(break3)
	);

endmodule

// File: acpiDemosaic_checker.sv
`timescale 1ns/1ps

module acpiDemosaicChecker (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic pixelValid,
	input logic frameDone,
	input logic wbCyc,
	input logic wbStb,
	input logic wbAck
);

	// Ack only answers a live bus cycle
	ackInCycle: assert property (@(posedge clk) disable iff (reset)
		wbAck |-> (wbCyc && wbStb))
		else $error("wbAck outside a bus cycle");

	noBackToBackAck: assert property (@(posedge clk) disable iff (reset)
		!(wbAck && $past(wbAck)))
		else $error("wbAck high on two consecutive cycles");

	doneWithPixel: assert property (@(posedge clk) disable iff (reset)
		frameDone |-> pixelValid)
		else $error("frameDone without pixelValid");

	pixelOnBeat: assert property (@(posedge clk) disable iff (reset)
		pixelValid |-> inValid)
		else $error("pixelValid without inValid");

endmodule

bind acpiDemosaic acpiDemosaicChecker acpiDemosaicChecker_inst (
	.clk(clk), .reset(reset), .inValid(inValid), .pixelValid(pixelValid),
	.frameDone(frameDone), .wbCyc(wbCyc), .wbStb(wbStb), .wbAck(wbAck)
);

// File: tbAcpiDemosaic.sv
`timescale 1ns/1ps

module tbAcpiDemosaic;
	import demosaicPkg::*;

	localparam int numFrames = 5;
	localparam int beatsPerFrame = framePixels + flushBeats;
	// Five frames of 57 beats plus random gaps and about 40 bus cycles stay far below this
	localparam int maxCycles = 2000;

	logic clk = 1'b0;
	logic reset = 1'b1;
	pixelT inData = '0;
	logic inValid = 1'b0;
	pixelT red;
	pixelT green;
	pixelT blue;
	logic pixelValid;
	logic frameDone;
	thresholdT threshold;
	logic wbCyc = 1'b0;
	logic wbStb = 1'b0;
	logic wbWe = 1'b0;
	wbAddrT wbAddr = '0;
	wbDataT wbDataIn = '0;
	wbDataT wbDataOut;
	logic wbAck;

	integer seed = 6;
	int cycleCount = 0;
	int pixelCount = 0;
	pixelT frameData [numFrames][framePixels];
	activityT refSum [numFrames];
	activityT tbBreak [4] = '{24'd200, 24'd300, 24'd450, 24'd900};
	// Expected {red, green, blue, activity} in raster order
	logic [32:0] expPixels [$];
	logic thresholdPending = 1'b0;
	thresholdT pendingThreshold;
	wbDataT readData;

	acpiDemosaic acpiDemosaic_inst (
		.clk(clk), .reset(reset), .inData(inData), .inValid(inValid),
		.red(red), .green(green), .blue(blue),
		.pixelValid(pixelValid), .frameDone(frameDone), .threshold(threshold),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAddr(wbAddr),
		.wbDataIn(wbDataIn), .wbDataOut(wbDataOut), .wbAck(wbAck)
	);

	always #5 clk = ~clk;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= maxCycles) begin
			abortRun("Timeout: the run did not finish within the cycle limit");
		end
	end

	task automatic comparePixel(input string name, input pixelT expected, input pixelT actual);
		if (actual !== expected) begin
			abortRun($sformatf("Fail at time %0t: %s expected %0d, got %0d",
				$time, name, expected, actual));
		end
	endtask

	task automatic compareFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			abortRun($sformatf("Fail at time %0t: %s expected %0b, got %0b",
				$time, name, expected, actual));
		end
	endtask

	task automatic compareThreshold(input string name, input thresholdT expected,
			input thresholdT actual);
		if (actual !== expected) begin
			abortRun($sformatf("Fail at time %0t: %s expected %0d, got %0d",
				$time, name, expected, actual));
		end
	endtask

	task automatic compareActivity(input string name, input activityT expected,
			input activityT actual);
		if (actual !== expected) begin
			abortRun($sformatf("Fail at time %0t: %s expected %0d, got %0d",
				$time, name, expected, actual));
		end
	endtask

	task automatic compareWord(input string name, input wbDataT expected, input wbDataT actual);
		if (actual !== expected) begin
			abortRun($sformatf("Fail at time %0t: %s expected %0d, got %0d",
				$time, name, expected, actual));
		end
	endtask

	// Expected {red, green, blue, activity} for one site, zero outside the frame
	function automatic logic [32:0] refPixel(input int n, input int x, input int y);
		int left, right, up, down, centre, h, v, gH, gV, gSel, parity;
		left = (x > 0) ? frameData[n][y * frameWidth + x - 1] : 0;
		right = (x < frameWidth - 1) ? frameData[n][y * frameWidth + x + 1] : 0;
		up = (y > 0) ? frameData[n][(y - 1) * frameWidth + x] : 0;
		down = (y < frameHeight - 1) ? frameData[n][(y + 1) * frameWidth + x] : 0;
		centre = frameData[n][y * frameWidth + x];
		h = (left > right) ? left - right : right - left;
		v = (up > down) ? up - down : down - up;
		gH = (x == 0) ? right : ((x == frameWidth - 1) ? left : (left + right) / 2);
		gV = (y == 0) ? down : ((y == frameHeight - 1) ? up : (up + down) / 2);
		if (h > v)
			gSel = gV;
		else if (h < v)
			gSel = gH;
		else
			gSel = (gH + gV) / 2;
		parity = (y % 2) * 2 + (x % 2);
		case (parity)
			1: return {8'd0, pixelT'(gSel), pixelT'(centre), gradSumT'(h + v)};
			2: return {pixelT'(centre), pixelT'(gSel), 8'd0, gradSumT'(h + v)};
			default: return {8'd0, pixelT'(centre), 8'd0, 9'd0};
		endcase
	endfunction

	function automatic thresholdT refThreshold(input activityT sum);
		if (sum < tbBreak[0])
			return 8'd50;
		else if (sum < tbBreak[1])
			return 8'd40;
		else if (sum < tbBreak[2])
			return 8'd20;
		else if (sum < tbBreak[3])
			return 8'd15;
		else
			return 8'd8;
	endfunction

	task automatic prepareFrame(input int n, input logic flat, input pixelT flatValue);
		logic [32:0] expected;
		refSum[n] = '0;
		for (int i = 0; i < framePixels; i++) begin
			frameData[n][i] = flat ? flatValue : pixelT'($random(seed));
		end
		for (int y = 0; y < frameHeight; y++) begin
			for (int x = 0; x < frameWidth; x++) begin
				expected = refPixel(n, x, y);
				expPixels.push_back(expected);
				refSum[n] = refSum[n] + activityT'(expected[8:0]);
			end
		end
	endtask

	// Beats first to last-1 of frame n, flush beats carry random filler
	task automatic driveBeats(input int n, input int first, input int last, input logic gaps);
		for (int i = first; i < last; i++) begin
			while (gaps && (($random(seed) & 3) == 0)) begin
				@(negedge clk);
				inValid = 1'b0;
				inData = pixelT'($random(seed));
			end
			@(negedge clk);
			inValid = 1'b1;
			inData = (i < framePixels) ? frameData[n][i] : pixelT'($random(seed));
		end
		@(negedge clk);
		inValid = 1'b0;
	endtask

	task automatic busCycle(input logic write, input wbAddrT addr, input wbDataT data,
			output wbDataT rdata);
		@(negedge clk);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = write;
		wbAddr = addr;
		wbDataIn = data;
		@(negedge clk);
		while (!wbAck) begin
			@(negedge clk);
		end
		rdata = wbDataOut;
		// Strobe stays up through the edge that samples the ack
		@(negedge clk);
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic compareFrame(input int n);
		thresholdT expThreshold;
		expThreshold = refThreshold(refSum[n]);
		busCycle(1'b0, addrThreshold, '0, readData);
		compareThreshold("threshold register", expThreshold, thresholdT'(readData));
		busCycle(1'b0, addrActivity, '0, readData);
		compareActivity("activity register", refSum[n], activityT'(readData));
		compareThreshold("threshold", expThreshold, threshold);
	endtask

	// Compare process, one pixel per accepted beat with pixelValid
	always @(posedge clk) begin
		logic [32:0] expected;
		if (thresholdPending) begin
			thresholdPending = 1'b0;
			compareThreshold("threshold", pendingThreshold, threshold);
		end
		if (pixelValid === 1'b1 && inValid !== 1'b1) begin
			abortRun("pixelValid was high while inValid was low");
		end
		if (pixelValid === 1'b1) begin
			if (expPixels.size() == 0) begin
				abortRun("A pixel left the DUT when none was expected");
			end
			expected = expPixels.pop_front();
			comparePixel("red", expected[32:25], red);
			comparePixel("green", expected[24:17], green);
			comparePixel("blue", expected[16:9], blue);
			pixelCount = pixelCount + 1;
			compareFlag("frameDone", (pixelCount % framePixels) == 0, frameDone);
			if (frameDone) begin
				pendingThreshold = refThreshold(refSum[pixelCount / framePixels - 1]);
				thresholdPending = 1'b1;
			end
		end
	end

	initial begin
		wbDataT resetWords [7];
		resetWords = '{32'd200, 32'd300, 32'd450, 32'd900, 32'd8, 32'd0, 32'd0};
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int a = 0; a < 7; a++) begin
			busCycle(1'b0, wbAddrT'(a), '0, readData);
			compareWord($sformatf("register %0d", a), resetWords[a], readData);
		end
		compareThreshold("threshold", 8'd8, threshold);

		// The first beats of each frame push out the tail of the one before
		prepareFrame(0, 1'b0, '0);
		driveBeats(0, 0, beatsPerFrame, 1'b0);
		// Flat frame, borders still see a gradient against the zero padding
		prepareFrame(1, 1'b1, 8'd5);
		driveBeats(1, 0, 4, 1'b0);
		compareFrame(0);
		driveBeats(1, 4, beatsPerFrame, 1'b0);

		prepareFrame(2, 1'b0, '0);
		driveBeats(2, 0, 4, 1'b1);
		compareFrame(1);
		driveBeats(2, 4, beatsPerFrame, 1'b1);

		prepareFrame(3, 1'b0, '0);
		driveBeats(3, 0, 4, 1'b0);
		compareFrame(2);
		// Breakpoints placed around the sum of frame 3
		tbBreak = '{refSum[3] >> 2, refSum[3] >> 1, refSum[3], refSum[3] + 24'd1};
		for (int i = 0; i < 4; i++) begin
			busCycle(1'b1, wbAddrT'(i), wbDataT'(tbBreak[i]), readData);
			busCycle(1'b0, wbAddrT'(i), '0, readData);
			compareWord($sformatf("breakpoint %0d", i), wbDataT'(tbBreak[i]), readData);
		end
		driveBeats(3, 4, beatsPerFrame, 1'b0);

		prepareFrame(4, 1'b0, '0);
		driveBeats(4, 0, 4, 1'b0);
		compareFrame(3);

		if (pixelCount != 4 * framePixels) begin
			abortRun($sformatf("Expected %0d pixels but the DUT sent %0d",
				4 * framePixels, pixelCount));
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

// File: acpiDemosaic.f
demosaicPkg.sv
bayerWindow.sv
greenInterp.sv
greyActivity.sv
thresholdRegs.sv
acpiDemosaic.sv
acpiDemosaic_checker.sv
tbAcpiDemosaic.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tbAcpiDemosaic -f acpiDemosaic.f
output=$(./obj_dir/VtbAcpiDemosaic) || true
echo "$output"
if echo "$output" | grep -q "TEST RESULT: PASS"; then
	exit 0
fi
exit 1
